/* sim.f */
source/mem_cfg_pkg.sv
source/mem_types_pkg.sv
source/store_align.sv
source/sync_ram_wbe.sv
source/load_align.sv
source/data_mem.sv
tests/data_mem_tb.sv

/* Makefile */
# Verilator build and run for the data memory testbench

VERILATOR ?= verilator
TOP       := data_mem_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  := Testbench passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

/* tests/data_mem_tb.sv */
// Self-checking testbench for the data memory, run from sim.f with a byte-array reference model
`default_nettype none
`timescale 1ns/1ps

module data_mem_tb
  import mem_cfg_pkg::*;
  import mem_types_pkg::*;
();

  localparam int CLK_PERIOD = 8;           // ns
  localparam int RST_CYCLES = 4;
  localparam int N_DIRECTED = 128;         // Upper bound on directed requests and drains
  localparam int N_RANDOM   = 400;         // Random requests, at most one idle slot each
  localparam int WATCHDOG_NS =
    (N_DIRECTED + 2 * N_RANDOM + RST_CYCLES + 20) * CLK_PERIOD;

  // Expected response with the request that caused it
  typedef struct packed {
    mem_req_t req;      // Issued request
    mem_rsp_t rsp;      // Predicted response
    int       edge_no;  // Cycle in which the request was driven
  } exp_entry_t;

  logic     clk = 1'b0;
  logic     rst;
  logic     req_valid;
  mem_req_t req;
  logic     rsp_valid;
  mem_rsp_t rsp;

  logic [7:0] model [DEPTH * NBYTES] = '{default: 8'h00};  // Byte image of the RAM
  exp_entry_t exp_q [$];                                 // Outstanding responses
  int         cycle   = 0;                               // Posedge counter
  int         errors  = 0;
  int         checked = 0;
  int         issued  = 0;
  int         seed    = 32'hcef5;

  data_mem u_data_mem (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // Little-endian byte model, stores applied in issue order
  function automatic mem_rsp_t expected_rsp(input mem_req_t r);
    mem_rsp_t e;
    int       a;
    logic     mis;
    a   = int'(r.addr);
    e   = '0;
    mis = 1'b0;
    case (r.op)
      OP_LH, OP_LHU, OP_SH: mis = (a % 2) != 0;       // Half needs even address
      OP_LW, OP_SW:         mis = (a % NBYTES) != 0;  // Word needs multiple of 4
      default:              mis = 1'b0;
    endcase
    e.misaligned = mis;
    e.is_load = (r.op == OP_LB) || (r.op == OP_LH) || (r.op == OP_LW) ||
                (r.op == OP_LBU) || (r.op == OP_LHU);
    if (!mis) begin
      case (r.op)
        OP_LB:  e.rdata = {{(XLEN - 8){model[a][7]}}, model[a]};
        OP_LBU: e.rdata = {{(XLEN - 8){1'b0}}, model[a]};
        OP_LH:  e.rdata = {{(XLEN - 16){model[a + 1][7]}}, model[a + 1], model[a]};
        OP_LHU: e.rdata = {{(XLEN - 16){1'b0}}, model[a + 1], model[a]};
        OP_LW:  e.rdata = {model[a + 3], model[a + 2], model[a + 1], model[a]};
        OP_SB: begin
          model[a] = r.wdata[7:0];
        end
        OP_SH: begin
          model[a]     = r.wdata[7:0];
          model[a + 1] = r.wdata[15:8];
        end
        OP_SW: begin
          for (int b = 0; b < NBYTES; b++) begin
            model[a + b] = r.wdata[b*8 +: 8];  // Lane b at byte a+b
          end
        end
        default: e.rdata = '0;
      endcase
    end
    return e;
  endfunction

  task automatic report_mismatch(input string what, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp, input mem_req_t r);
    $display("Fail at %0t: %s got %h expected %h (op %s addr %h)",
             $time, what, got, exp, r.op.name(), r.addr);
    errors++;
  endtask

  // Compare on the falling edge, then log any request issued this cycle
  always @(negedge clk) begin : compare
    exp_entry_t e;
    exp_entry_t n;
    if (!rst) begin
      if (rsp_valid) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: response arrived with no request outstanding", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          checked++;
          assert (cycle - e.edge_no == RSP_LATENCY)
            else report_mismatch("latency", XLEN'(cycle - e.edge_no), RSP_LATENCY, e.req);
          assert (rsp.rdata == e.rsp.rdata)
            else report_mismatch("rdata", rsp.rdata, e.rsp.rdata, e.req);
          assert (rsp.misaligned == e.rsp.misaligned)
            else report_mismatch("misaligned", XLEN'(rsp.misaligned),
                                 XLEN'(e.rsp.misaligned), e.req);
          assert (rsp.is_load == e.rsp.is_load)
            else report_mismatch("is_load", XLEN'(rsp.is_load), XLEN'(e.rsp.is_load), e.req);
        end
      end else if (exp_q.size() != 0 && cycle - exp_q[0].edge_no >= RSP_LATENCY) begin
        $display("Error at %0t: response for a request never arrived", $time);
        errors++;
        void'(exp_q.pop_front());
      end
      if (req_valid) begin
        n.req     = req;
        n.rsp     = expected_rsp(req);
        n.edge_no = cycle;                    // Response due RSP_LATENCY cycles later
        exp_q.push_back(n);
        issued++;
      end
    end
  end

  task automatic send(input mem_op_e op, input int addr, input logic [XLEN-1:0] data);
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= '{op: op, addr: BYTE_AW'(addr), wdata: data};
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      req_valid <= 1'b0;
    end
  endtask

  // Let every outstanding response come back
  task automatic drain;
    idle(1);
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic word_roundtrip;
    send(OP_LW, 'h000, '0);                   // Untouched words read zero
    send(OP_LW, 'h3fc, '0);
    send(OP_LW, 'h120, '0);
    for (int i = 0; i < 4; i++) begin
      send(OP_SW, 'h010 + 'h104 * i, 32'hdead_beef ^ (32'h0101_0101 << i));
      send(OP_LW, 'h010 + 'h104 * i, '0);
    end
  endtask

  task automatic subword_stores;
    send(OP_SW, 'h040, 32'h1122_3344);
    for (int off = 0; off < NBYTES; off++) begin
      send(OP_SB, 'h040 + off, 32'hffff_ff00 | (off * 16 + 5));  // Upper bits ignored
      send(OP_LW, 'h040, '0);
    end
    for (int off = 0; off < NBYTES; off += 2) begin
      send(OP_SH, 'h050 + off, 32'hffff_0000 | (32'h1234 + off));
      send(OP_LW, 'h050, '0);
    end
  endtask

  task automatic load_extension;
    send(OP_SW, 'h080, 32'h807f_ff01);        // Bytes with top bit set and clear
    send(OP_SW, 'h084, 32'h7fff_8000);        // Halves with top bit set and clear
    for (int w = 0; w < 2; w++) begin
      for (int off = 0; off < NBYTES; off++) begin
        send(OP_LB, 'h080 + 4 * w + off, '0);
        send(OP_LBU, 'h080 + 4 * w + off, '0);
      end
      for (int off = 0; off < NBYTES; off += 2) begin
        send(OP_LH, 'h080 + 4 * w + off, '0);
        send(OP_LHU, 'h080 + 4 * w + off, '0);
      end
    end
  endtask

  task automatic misalignment;
    send(OP_SW, 'h0c0, 32'h0bad_cafe);
    send(OP_SH, 'h0c1, 32'hffff_ffff);
    send(OP_SH, 'h0c3, 32'hffff_ffff);
    for (int off = 1; off < NBYTES; off++) begin
      send(OP_SW, 'h0c0 + off, 32'hffff_ffff);
    end
    send(OP_LH, 'h0c1, '0);
    send(OP_LHU, 'h0c3, '0);
    for (int off = 1; off < NBYTES; off++) begin
      send(OP_LW, 'h0c0 + off, '0);
    end
    send(OP_LW, 'h0c0, '0);                   // Word must be unchanged
  endtask

  task automatic back_to_back;
    for (int i = 0; i < 8; i++) begin
      send(OP_SW, 'h200 + 4 * i, 32'h5a00_0000 + 32'h0011_2233 * i);
      send(OP_LW, 'h200 + 4 * i, '0);         // Next cycle, same word
    end
    for (int i = 0; i < 8; i++) begin
      send(OP_SB, 'h300 + 4 * i + i % NBYTES, 32'h0000_0080 + i);
      send((i % 2 == 0) ? OP_LB : OP_LBU, 'h300 + 4 * i + i % NBYTES, '0);
    end
  endtask

  task automatic random_mix(input int n);
    int r;
    int addr;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      if (r[3:0] < 4'd6) begin
        idle(1);                              // Roughly 70 percent valid
      end
      addr = $random(seed) & ((1 << BYTE_AW) - 1);
      if (r[7]) begin
        addr = addr & 'h7f;                   // Cluster on low words for hits
      end
      if (r[8]) begin
        addr = addr & ~(NBYTES - 1);          // Bias toward aligned
      end
      send(mem_op_e'(r[6:4]), addr, $random(seed));
    end
  endtask

  initial begin
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    word_roundtrip();
    drain();
    subword_stores();
    drain();
    load_extension();
    drain();
    misalignment();
    drain();
    back_to_back();
    drain();
    random_mix(N_RANDOM);
    drain();
    idle(4);
    $display("Summary: %0d of %0d responses checked, %0d errors", checked, issued, errors);
    if (errors == 0 && checked == issued && exp_q.size() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all responses came back");
    $display("Summary: %0d of %0d responses checked, %0d errors", checked, issued, errors);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* source/data_mem.sv */
// Top level of the data memory chaining store side, byte-enable RAM and load side
`default_nettype none
`timescale 1ns/1ps

module data_mem
  import mem_cfg_pkg::*;
  import mem_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst,        // Synchronous, active high
  input  logic     req_valid,  // One request per strobe, no stall
  input  mem_req_t req,        // Op, byte address, store data
  output logic     rsp_valid,  // Two edges after the request edge
  output mem_rsp_t rsp         // Load data and fault flags
);

  // Store side to RAM
  logic               ram_en;    // Access strobe
  logic [NBYTES-1:0]  ram_wbe;   // Byte lanes written
  logic [WORD_AW-1:0] ram_addr;  // Word index
  logic [XLEN-1:0]    ram_d;     // Lane-shifted data

  // RAM to load side
  logic [XLEN-1:0]    ram_q;     // Read-first word

  // Store side to load side, bypassing the RAM
  mem_meta_t          meta;      // Op, offset, fault, valid

  // Alignment, byte enables and lane data, all combinational
  store_align u_store_align (
    .req_valid (req_valid),
    .req       (req),
    .ram_en    (ram_en),
    .ram_wbe   (ram_wbe),
    .ram_addr  (ram_addr),
    .ram_d     (ram_d),
    .meta      (meta)
  );

  // Storage, one cycle read latency
  sync_ram_wbe u_sync_ram_wbe (
    .clk  (clk),
    .en   (ram_en),
    .wbe  (ram_wbe),
    .addr (ram_addr),
    .d    (ram_d),
    .q    (ram_q)
  );

  // Meta register, extraction and response register
  load_align u_load_align (
    .clk       (clk),
    .rst       (rst),
    .meta_in   (meta),
    .ram_q     (ram_q),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

/* source/load_align.sv */
// Load-side back end that lines metadata up with RAM data and forms the registered response
`default_nettype none
`timescale 1ns/1ps

module load_align
  import mem_cfg_pkg::*;
  import mem_types_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  mem_meta_t       meta_in,    // Slot info from the store side
  input  logic [XLEN-1:0] ram_q,      // RAM word, valid one cycle after en
  output logic            rsp_valid,  // Response strobe
  output mem_rsp_t        rsp         // Response payload
);

  mem_meta_t       meta_q;     // Meta aligned with ram_q
  logic [7:0]      sel_byte;   // Addressed byte
  logic [15:0]     sel_half;   // Addressed half
  logic            is_load;    // Slot is a load
  logic [XLEN-1:0] load_data;  // Extended result
  mem_rsp_t        rsp_d;      // Next response

  // Stage 1: follow the RAM read by one cycle
  always_ff @(posedge clk) begin
    meta_q <= meta_in;
    if (rst) begin
      meta_q.valid <= 1'b0;  // Only the valid bit is control
    end
  end

  // Lane select by offset
  assign sel_byte = ram_q[{meta_q.offset, 3'b000} +: 8];
  assign sel_half = ram_q[{meta_q.offset[1], 4'b0000} +: 16];

  // Extension per operation
  always_comb begin
    is_load   = 1'b1;
    load_data = ram_q;
    case (meta_q.op)
      OP_LB:  load_data = {{(XLEN - 8){sel_byte[7]}}, sel_byte};
      OP_LBU: load_data = {{(XLEN - 8){1'b0}}, sel_byte};
      OP_LH:  load_data = {{(XLEN - 16){sel_half[15]}}, sel_half};
      OP_LHU: load_data = {{(XLEN - 16){1'b0}}, sel_half};
      OP_LW:  load_data = ram_q;
      OP_SB, OP_SH, OP_SW: begin
        is_load   = 1'b0;
        load_data = '0;      // Stores return no data
      end
    endcase
    if (meta_q.misaligned) begin
      load_data = '0;        // Faulted access returns zero
    end
  end

  assign rsp_d = '{
    rdata:      load_data,
    misaligned: meta_q.misaligned,
    is_load:    is_load
  };

  // Stage 2: registered response
  always_ff @(posedge clk) begin
    rsp <= rsp_d;
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= meta_q.valid;  // One response per live slot
    end
  end

endmodule

`default_nettype wire

/* source/sync_ram_wbe.sv */
// Single-port block RAM with byte write enables and a registered read-first output
`default_nettype none
`timescale 1ns/1ps

module sync_ram_wbe
  import mem_cfg_pkg::*;
(
  input  logic               clk,
  input  logic               en,    // Access strobe
  input  logic [NBYTES-1:0]  wbe,   // Byte lanes to write
  input  logic [WORD_AW-1:0] addr,  // Word address
  input  logic [XLEN-1:0]    d,     // Write data, already in its lanes
  output logic [XLEN-1:0]    q      // Old word, one cycle after en
);

  // Storage, cleared at start so loads before any store return zero
  logic [XLEN-1:0] mem [DEPTH] = '{default: '0};

  // Write and read on the same edge
  // The nonblocking read picks up the word as it was before this edge,
  // so a store returns its old contents and a load one cycle later
  // sees the freshly written bytes
  always_ff @(posedge clk) begin
    if (en) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (wbe[b]) begin
          mem[addr][b*8 +: 8] <= d[b*8 +: 8];  // Enabled lane only
        end
      end
      q <= mem[addr];                          // Read-first output
    end
  end

endmodule

`default_nettype wire

/* source/store_align.sv */
// Store-side front end that checks alignment and builds byte enables, lane data and metadata
`default_nettype none
`timescale 1ns/1ps

module store_align
  import mem_cfg_pkg::*;
  import mem_types_pkg::*;
(
  input  logic               req_valid,  // One-cycle request strobe
  input  mem_req_t           req,        // Request payload
  output logic               ram_en,     // RAM access this cycle
  output logic [NBYTES-1:0]  ram_wbe,    // Per-byte write enables
  output logic [WORD_AW-1:0] ram_addr,   // Word address
  output logic [XLEN-1:0]    ram_d,      // Lane-replicated write data
  output mem_meta_t          meta        // Slot info for the load side
);

  logic [1:0]        offset;      // Byte lane of the access
  logic              is_store;    // SB/SH/SW
  logic              misaligned;  // Natural alignment broken
  logic [NBYTES-1:0] size_mask;   // Access size, lane 0 based

  assign offset   = req.addr[1:0];
  assign ram_en   = req_valid;               // Every request touches the RAM
  assign ram_addr = req.addr[BYTE_AW-1:2];   // Drop the lane bits

  // Decode size and alignment per operation
  always_comb begin
    is_store   = 1'b0;
    misaligned = 1'b0;
    size_mask  = '0;
    ram_d      = req.wdata;
    case (req.op)
      OP_LB, OP_LBU: begin
        misaligned = 1'b0;                  // Bytes are always aligned
      end
      OP_LH, OP_LHU: begin
        misaligned = offset[0];             // Halves need an even address
      end
      OP_LW: begin
        misaligned = |offset;               // Words need a multiple of 4
      end
      OP_SB: begin
        is_store   = 1'b1;
        size_mask  = NBYTES'(1);
        ram_d      = {NBYTES{req.wdata[7:0]}};       // Byte into every lane
      end
      OP_SH: begin
        is_store   = 1'b1;
        misaligned = offset[0];
        size_mask  = NBYTES'(3);
        ram_d      = {(NBYTES / 2){req.wdata[15:0]}}; // Half into both halves
      end
      OP_SW: begin
        is_store   = 1'b1;
        misaligned = |offset;
        size_mask  = '1;
      end
    endcase
  end

  // Misaligned stores leave memory untouched
  assign ram_wbe = (is_store && !misaligned) ? (size_mask << offset) : '0;

  assign meta = '{
    valid:      req_valid,
    op:         req.op,
    offset:     offset,
    misaligned: misaligned
  };

endmodule

`default_nettype wire

/* source/mem_types_pkg.sv */
// Operation encoding and the request, metadata and response structs of the data memory
`default_nettype none

package mem_types_pkg;

  import mem_cfg_pkg::*;

  // Load/store operations
  typedef enum logic [2:0] {
    OP_LB  = 3'd0,  // Byte, sign-extended
    OP_LH  = 3'd1,  // Half, sign-extended
    OP_LW  = 3'd2,  // Word
    OP_LBU = 3'd3,  // Byte, zero-extended
    OP_LHU = 3'd4,  // Half, zero-extended
    OP_SB  = 3'd5,  // Store byte
    OP_SH  = 3'd6,  // Store half
    OP_SW  = 3'd7   // Store word
  } mem_op_e;

  // Request as issued by the core
  typedef struct packed {
    mem_op_e              op;     // Operation
    logic [BYTE_AW-1:0]   addr;   // Byte address
    logic [XLEN-1:0]      wdata;  // Store data, low bits used for SB/SH
  } mem_req_t;

  // Travels alongside the RAM read so the load side knows what to extract
  typedef struct packed {
    logic                 valid;       // Live slot
    mem_op_e              op;          // Operation of this slot
    logic [1:0]           offset;      // Byte lane within the word
    logic                 misaligned;  // Alignment fault
  } mem_meta_t;

  // Response returned to the core
  typedef struct packed {
    logic [XLEN-1:0]      rdata;       // Extended load data, zero otherwise
    logic                 misaligned;  // Request was not naturally aligned
    logic                 is_load;     // Set for LB/LH/LW/LBU/LHU
  } mem_rsp_t;

endpackage

`default_nettype wire

/* source/mem_cfg_pkg.sv */
// Sizing constants for the data memory, imported by every RTL block and the testbench
`default_nettype none

package mem_cfg_pkg;

  // Data path
  localparam int XLEN = 32;              // Word width in bits
  localparam int NBYTES = XLEN / 8;      // Byte lanes per word

  // Storage
  localparam int WORD_AW = 8;            // Word address bits
  localparam int DEPTH = 1 << WORD_AW;   // Words in the RAM

  // Byte address is the word address plus the lane offset
  localparam int BYTE_AW = WORD_AW + $clog2(NBYTES);

  // Request edge to rsp_valid edge
  // One cycle in the RAM, one in the load-side response register
  localparam int RSP_LATENCY = 2;

endpackage

`default_nettype wire
